/* digital_clock.f */
source/clock_pkg.sv
source/tick_gen.sv
source/button_sync.sv
source/clock_ctrl.sv
source/time_keeper.sv
source/display_scan.sv
source/digital_clock.sv
test/digital_clock_assert.sv
test/tb_clock_gen.sv
test/tb_digital_clock.sv

/* run_sim.sh */
#!/bin/sh
# Builds the clock testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module tb_digital_clock \
	-f digital_clock.f -o sim_digital_clock; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/sim_digital_clock 2>&1)
status=$?
printf '%s\n' "$output"

if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "Regression passed"; then
	exit 0
fi
echo "Pass line not found in simulation output"
exit 1

/* source/button_sync.sv */
// Button front end, samples the active-low buttons and turns each new press into a pulse
`timescale 1ns/100ps

module button_sync import clock_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	input  logic i_sample_tick,
	input  btn_t i_btn,
	output btn_t o_press
);

	btn_t btn_meta;		// Raw level into the clk domain
	btn_t btn_sync;
	btn_t hist_1;		// Last sample
	btn_t hist_2;		// Sample before it
	btn_t press_det;

	// Released before, then two low samples in a row
	assign press_det = btn_t'(hist_2 & ~hist_1 & ~btn_sync);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			btn_meta <= '1;		// All released
			btn_sync <= '1;
		end else begin
			btn_meta <= i_btn;
			btn_sync <= btn_meta;
		end
	end

	// --------------------
	// Sample history
	// --------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			hist_1  <= '1;
			hist_2  <= '1;
			o_press <= '0;
		end else begin
			if (i_sample_tick) begin
				hist_1  <= btn_sync;
				hist_2  <= hist_1;
				o_press <= press_det;	// One clk wide
			end else begin
				o_press <= '0;
			end
		end
	end

endmodule

/* source/clock_ctrl.sv */
// Clock controller, steps mode and field from the press pulses and routes the increment button
`timescale 1ns/100ps

module clock_ctrl import clock_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  btn_t       i_press,
	output ctrl_t      o_ctrl,
	output logic [2:0] o_time_inc,	// {hou, min, sec}
	output logic [2:0] o_alarm_inc	// {hou, min, sec}
);

	ctrl_t      ctrl;
	logic [2:0] field_sel;	// Selected field, one-hot

	// --------------------
	// Mode, position, enable
	// --------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ctrl.mode     <= MODE_CLOCK;
			ctrl.pos      <= POS_SEC;
			ctrl.alarm_en <= 1'b0;
		end else begin
			if (i_press.mode) begin
				case (ctrl.mode)
					MODE_CLOCK: ctrl.mode <= MODE_SETUP;
					MODE_SETUP: ctrl.mode <= MODE_ALARM;
					default:    ctrl.mode <= MODE_CLOCK;
				endcase
			end
			if (i_press.pos) begin
				case (ctrl.pos)
					POS_SEC: ctrl.pos <= POS_MIN;
					POS_MIN: ctrl.pos <= POS_HOU;
					default: ctrl.pos <= POS_SEC;
				endcase
			end
			if (i_press.alarm)
				ctrl.alarm_en <= ~ctrl.alarm_en;	// Toggle
		end
	end

	always_comb begin
		case (ctrl.pos)
			POS_SEC: field_sel = 3'b001;
			POS_MIN: field_sel = 3'b010;
			POS_HOU: field_sel = 3'b100;
			default: field_sel = 3'b000;
		endcase
	end

	// Increment goes to time in setup, to alarm in alarm mode, nowhere otherwise
	assign o_time_inc  = (i_press.inc && ctrl.mode == MODE_SETUP) ? field_sel : 3'b000;
	assign o_alarm_inc = (i_press.inc && ctrl.mode == MODE_ALARM) ? field_sel : 3'b000;

	assign o_ctrl = ctrl;

endmodule

/* source/clock_pkg.sv */
// Shared types, constants and the digit decoder, imported by every clock module
package clock_pkg;

	// --------------------
	// Modes and fields
	// --------------------
	typedef enum logic [1:0] {
		MODE_CLOCK = 2'd0,	// Time runs, time shown
		MODE_SETUP = 2'd1,	// Time frozen, fields stepped
		MODE_ALARM = 2'd2	// Time runs, alarm shown and stepped
	} mode_t;

	typedef enum logic [1:0] {
		POS_SEC = 2'd0,
		POS_MIN = 2'd1,
		POS_HOU = 2'd2
	} pos_t;

	typedef struct packed {
		logic [5:0] hou;
		logic [5:0] min;
		logic [5:0] sec;
	} hms_t;

	typedef struct packed {
		mode_t mode;
		pos_t  pos;
		logic  alarm_en;
	} ctrl_t;

	// One bit per push button
	typedef struct packed {
		logic mode;
		logic pos;
		logic inc;
		logic alarm;
	} btn_t;

	typedef logic [6:0] seg_t;	// {a, b, c, d, e, f, g}, lit when high

	localparam logic [5:0] SEC_MAX    = 6'd59;	// Also the minute limit
	localparam logic [5:0] HOU_MAX    = 6'd23;
	localparam int         NUM_DIGITS = 6;

	// Decimal digit to segments, blank above 9
	function automatic seg_t seg_of_digit(input logic [3:0] digit);
		case (digit)
			4'd0:    return 7'b111_1110;
			4'd1:    return 7'b011_0000;
			4'd2:    return 7'b110_1101;
			4'd3:    return 7'b111_1001;
			4'd4:    return 7'b011_0011;
			4'd5:    return 7'b101_1011;
			4'd6:    return 7'b101_1111;
			4'd7:    return 7'b111_0000;
			4'd8:    return 7'b111_1111;
			4'd9:    return 7'b111_0011;
			default: return 7'b000_0000;
		endcase
	endfunction

endpackage

/* source/digital_clock.sv */
// Top level of the digital clock with alarm, connects ticks, buttons, control, time and display
`timescale 1ns/100ps

module digital_clock import clock_pkg::*; #(
	parameter int unsigned SEC_DIV    = 50_000_000,	// clk cycles per second
	parameter int unsigned SCAN_DIV   = 50_000,		// clk cycles per digit
	parameter int unsigned SAMPLE_DIV = 500_000		// clk cycles per button sample
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  btn_t                  i_btn,		// Low when pressed
	output seg_t                  o_seg,
	output logic [NUM_DIGITS-1:0] o_seg_enb,
	output logic                  o_seg_dp,
	output logic                  o_alarm
);

	logic       sec_tick;
	logic       scan_tick;
	logic       sample_tick;
	btn_t       press;
	ctrl_t      ctrl;
	logic [2:0] time_inc;
	logic [2:0] alarm_inc;
	hms_t       cur_time;
	hms_t       alarm_time;

	tick_gen #(
		.SEC_DIV    (SEC_DIV),
		.SCAN_DIV   (SCAN_DIV),
		.SAMPLE_DIV (SAMPLE_DIV)
	) u_tick_gen (
		.clk           (clk),
		.rst_n         (rst_n),
		.o_sec_tick    (sec_tick),
		.o_scan_tick   (scan_tick),
		.o_sample_tick (sample_tick)
	);

	button_sync u_button_sync (
		.clk           (clk),
		.rst_n         (rst_n),
		.i_sample_tick (sample_tick),
		.i_btn         (i_btn),
		.o_press       (press)
	);

	clock_ctrl u_clock_ctrl (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_press     (press),
		.o_ctrl      (ctrl),
		.o_time_inc  (time_inc),
		.o_alarm_inc (alarm_inc)
	);

	time_keeper u_time_keeper (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_sec_tick   (sec_tick),
		.i_ctrl       (ctrl),
		.i_time_inc   (time_inc),
		.i_alarm_inc  (alarm_inc),
		.o_time       (cur_time),
		.o_alarm_time (alarm_time),
		.o_alarm      (o_alarm)
	);

	display_scan u_display_scan (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_scan_tick  (scan_tick),
		.i_ctrl       (ctrl),
		.i_time       (cur_time),
		.i_alarm_time (alarm_time),
		.o_seg        (o_seg),
		.o_seg_enb    (o_seg_enb),
		.o_seg_dp     (o_seg_dp)
	);

endmodule

/* source/display_scan.sv */
// Display scanner, drives the six multiplexed seven-segment digits and the field marker point
`timescale 1ns/100ps

module display_scan import clock_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  i_scan_tick,
	input  ctrl_t                 i_ctrl,
	input  hms_t                  i_time,
	input  hms_t                  i_alarm_time,
	output seg_t                  o_seg,
	output logic [NUM_DIGITS-1:0] o_seg_enb,	// Active low
	output logic                  o_seg_dp
);

	localparam int IDX_W = $clog2(NUM_DIGITS);

	logic [IDX_W-1:0]      idx;		// Digit being driven
	hms_t                  shown;
	logic [5:0]            fields [3];	// sec, min, hou
	logic [3:0]            digits [NUM_DIGITS];
	logic [NUM_DIGITS-1:0] dp_mask;

	assign shown = (i_ctrl.mode == MODE_ALARM) ? i_alarm_time : i_time;

	// Even index holds the ones, odd index the tens
	always_comb begin
		fields[0] = shown.sec;
		fields[1] = shown.min;
		fields[2] = shown.hou;
		for (int i = 0; i < 3; i++) begin
			digits[2*i]   = 4'(fields[i] % 6'd10);
			digits[2*i+1] = 4'(fields[i] / 6'd10);
		end
	end

	// Setup marks the ones digit, alarm the tens digit
	always_comb begin
		case (i_ctrl.mode)
			MODE_SETUP: dp_mask = NUM_DIGITS'(1) << (2 * i_ctrl.pos);
			MODE_ALARM: dp_mask = NUM_DIGITS'(2) << (2 * i_ctrl.pos);
			default:    dp_mask = '0;
		endcase
	end

	// --------------------
	// Scan index
	// --------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			idx <= '0;
		else if (i_scan_tick)
			idx <= (idx == IDX_W'(NUM_DIGITS - 1)) ? '0 : idx + 1'b1;
	end

	// Registered outputs, one clk behind the index
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_seg     <= seg_of_digit(4'd0);
			o_seg_enb <= ~NUM_DIGITS'(1);	// Digit 0 on
			o_seg_dp  <= 1'b0;
		end else begin
			o_seg     <= seg_of_digit(digits[idx]);
			o_seg_enb <= ~(NUM_DIGITS'(1) << idx);
			o_seg_dp  <= dp_mask[idx];
		end
	end

endmodule

/* source/tick_gen.sv */
// Enable tick generator, turns clk into the seconds, display scan and button sample strobes
`timescale 1ns/100ps

module tick_gen #(
	parameter int unsigned SEC_DIV    = 50_000_000,
	parameter int unsigned SCAN_DIV   = 50_000,
	parameter int unsigned SAMPLE_DIV = 500_000
) (
	input  logic clk,
	input  logic rst_n,
	output logic o_sec_tick,
	output logic o_scan_tick,
	output logic o_sample_tick
);

	// One free-running divider per tick, g = 0 sec, 1 scan, 2 sample
	for (genvar g = 0; g < 3; g++) begin : g_div
		localparam int unsigned DIV = (g == 0) ? SEC_DIV : (g == 1) ? SCAN_DIV : SAMPLE_DIV;
		localparam int          CW  = (DIV > 1) ? $clog2(DIV) : 1;

		logic [CW-1:0] cnt;
		logic          tick;	// High for one clk on wrap

		always_ff @(posedge clk or negedge rst_n) begin
			if (!rst_n) begin
				cnt  <= '0;
				tick <= 1'b0;
			end else if (cnt == CW'(DIV - 1)) begin
				cnt  <= '0;
				tick <= 1'b1;
			end else begin
				cnt  <= cnt + 1'b1;
				tick <= 1'b0;
			end
		end
	end

	assign o_sec_tick    = g_div[0].tick;
	assign o_scan_tick   = g_div[1].tick;
	assign o_sample_tick = g_div[2].tick;

endmodule

/* source/time_keeper.sv */
// Timekeeper, holds the running time and the alarm time and latches the alarm on a match
`timescale 1ns/100ps

module time_keeper import clock_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       i_sec_tick,
	input  ctrl_t      i_ctrl,
	input  logic [2:0] i_time_inc,	// {hou, min, sec}
	input  logic [2:0] i_alarm_inc,
	output hms_t       o_time,
	output hms_t       o_alarm_time,
	output logic       o_alarm
);

	hms_t tm;	// Running time
	hms_t al;	// Alarm time
	logic run;

	// Step one field, back to zero past its limit
	function automatic logic [5:0] wrap_inc(input logic [5:0] val, input logic [5:0] max);
		return (val >= max) ? 6'd0 : val + 6'd1;
	endfunction

	// Time stands still only in setup
	assign run = i_sec_tick && (i_ctrl.mode == MODE_CLOCK || i_ctrl.mode == MODE_ALARM);

	// --------------------
	// Running time
	// --------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tm <= '0;
		end else if (run) begin
			tm.sec <= wrap_inc(tm.sec, SEC_MAX);
			if (tm.sec == SEC_MAX) begin	// Carry into minutes
				tm.min <= wrap_inc(tm.min, SEC_MAX);
				if (tm.min == SEC_MAX)
					tm.hou <= wrap_inc(tm.hou, HOU_MAX);
			end
		end else begin
			// Setup steps, no carry
			if (i_time_inc[0])
				tm.sec <= wrap_inc(tm.sec, SEC_MAX);
			if (i_time_inc[1])
				tm.min <= wrap_inc(tm.min, SEC_MAX);
			if (i_time_inc[2])
				tm.hou <= wrap_inc(tm.hou, HOU_MAX);
		end
	end

	// --------------------
	// Alarm time
	// --------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			al <= '0;
		end else begin
			if (i_alarm_inc[0])
				al.sec <= wrap_inc(al.sec, SEC_MAX);
			if (i_alarm_inc[1])
				al.min <= wrap_inc(al.min, SEC_MAX);
			if (i_alarm_inc[2])
				al.hou <= wrap_inc(al.hou, HOU_MAX);
		end
	end

	// Sticky until the enable drops
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			o_alarm <= 1'b0;
		else
			o_alarm <= i_ctrl.alarm_en & (o_alarm | (tm == al));
	end

	assign o_time       = tm;
	assign o_alarm_time = al;

endmodule

/* test/digital_clock_assert.sv */
// Concurrent checks on the clock top level, attached to every digital_clock by bind
`timescale 1ns/100ps

module digital_clock_assert import clock_pkg::*; (
	input logic                  clk,
	input logic                  rst_n,
	input logic [NUM_DIGITS-1:0] i_seg_enb,
	input logic                  i_alarm,
	input ctrl_t                 i_ctrl,
	input hms_t                  i_time,
	input hms_t                  i_alarm_time
);

	hms_t shown;	// Time on the display

	assign shown = (i_ctrl.mode == MODE_ALARM) ? i_alarm_time : i_time;

	a_one_digit: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot(~i_seg_enb)) else $error("Digit enables not one-hot low");

	// Alarm level needs the enable of the cycle before
	a_alarm_gated: assert property (@(posedge clk) disable iff (!rst_n)
		i_alarm |-> $past(i_ctrl.alarm_en)) else $error("Alarm set while disabled");

	a_time_range: assert property (@(posedge clk) disable iff (!rst_n)
		shown.hou <= HOU_MAX && shown.min <= SEC_MAX && shown.sec <= SEC_MAX)
		else $error("Shown time out of range");

endmodule

bind digital_clock digital_clock_assert u_assert (
	.clk          (clk),
	.rst_n        (rst_n),
	.i_seg_enb    (o_seg_enb),
	.i_alarm      (o_alarm),
	.i_ctrl       (ctrl),
	.i_time       (cur_time),
	.i_alarm_time (alarm_time)
);

/* test/tb_clock_gen.sv */
// Testbench clock and reset source, 100 ns clock with reset held low for the first cycles
`timescale 1ns/100ps

module tb_clock_gen #(
	parameter int PERIOD       = 100,
	parameter int RESET_CYCLES = 4
) (
	output logic clk,
	output logic rst_n
);

	initial clk = 1'b0;
	always #(PERIOD / 2) clk = ~clk;

	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#10 rst_n = 1'b1;	// Released off the edge
	end

endmodule

/* test/tb_digital_clock.sv */
// Directed testbench for the digital clock that runs as the simulation top with small tick dividers
`timescale 1ns/100ps

module tb_digital_clock import clock_pkg::*; ();

	localparam int   SEC_DIV = 40;
	localparam int   HOLD    = 16;	// clk cycles per button level
	localparam btn_t BTN_MODE  = 4'b1000;
	localparam btn_t BTN_POS   = 4'b0100;
	localparam btn_t BTN_INC   = 4'b0010;
	localparam btn_t BTN_ALARM = 4'b0001;
	localparam seg_t DIGIT_SEGS [10] = '{7'b1111110, 7'b0110000, 7'b1101101, 7'b1111001,
		7'b0110011, 7'b1011011, 7'b1011111, 7'b1110000, 7'b1111111, 7'b1110011};

	logic clk, rst_n, seg_dp, alarm;
	btn_t btn;
	seg_t seg;
	logic [NUM_DIGITS-1:0] seg_enb, rd_dp;
	seg_t        rd_seg [NUM_DIGITS];	// Last full scan
	int unsigned cycle_cnt = 0;
	int          value_errs = 0;
	int          timeout_errs = 0;
	mode_t       exp_mode = MODE_CLOCK;	// Expected control state
	pos_t        exp_pos = POS_SEC;
	hms_t        exp_time = '0;
	hms_t        exp_alarm = '0;

	tb_clock_gen i_clock_gen (.clk(clk), .rst_n(rst_n));

	digital_clock #(.SEC_DIV(SEC_DIV), .SCAN_DIV(2), .SAMPLE_DIV(3)) i_dut (
		.clk(clk), .rst_n(rst_n), .i_btn(btn), .o_seg(seg),
		.o_seg_enb(seg_enb), .o_seg_dp(seg_dp), .o_alarm(alarm)
	);

	always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

	// --------------------
	// Reference model
	// --------------------
	function automatic logic [5:0] field_of(input hms_t t, input pos_t p);
		case (p)
			POS_SEC: return t.sec;
			POS_MIN: return t.min;
			default: return t.hou;
		endcase
	endfunction

	function automatic hms_t bump(input hms_t t, input pos_t p);
		case (p)
			POS_SEC: t.sec = (t.sec == 6'd59) ? 6'd0 : t.sec + 6'd1;
			POS_MIN: t.min = (t.min == 6'd59) ? 6'd0 : t.min + 6'd1;
			default: t.hou = (t.hou == 6'd23) ? 6'd0 : t.hou + 6'd1;
		endcase
		return t;
	endfunction

	function automatic seg_t exp_seg(input hms_t t, input int d);
		logic [5:0] f;
		logic [3:0] digit;
		f = field_of(t, pos_t'(d / 2));
		digit = (d % 2 == 0) ? 4'(f % 6'd10) : 4'(f / 6'd10);	// Even index is the ones
		return DIGIT_SEGS[digit];
	endfunction

	// Setup marks the ones digit and alarm mode the tens digit
	function automatic logic [5:0] exp_points();
		case (exp_mode)
			MODE_SETUP:
				case (exp_pos)
					POS_SEC: return 6'b000001;
					POS_MIN: return 6'b000100;
					default: return 6'b010000;
				endcase
			MODE_ALARM:
				case (exp_pos)
					POS_SEC: return 6'b000010;
					POS_MIN: return 6'b001000;
					default: return 6'b100000;
				endcase
			default: return 6'b000000;
		endcase
	endfunction

	function automatic logic shows(input hms_t t);
		for (int d = 0; d < NUM_DIGITS; d++)
			if (rd_seg[d] !== exp_seg(t, d))
				return 1'b0;
		return 1'b1;
	endfunction

	// --------------------
	// Compare tasks
	// --------------------
	task automatic check_seg(input string name, input seg_t got, input seg_t exp);
		if (got !== exp) begin
			value_errs++;
			$display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_dp(input string name, input logic [5:0] got, input logic [5:0] exp);
		if (got !== exp) begin
			value_errs++;
			$display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			value_errs++;
			$display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	// --------------------
	// Stimulus and display
	// --------------------
	task automatic press_button(input btn_t b);
		@(posedge clk);
		#10 btn = btn_t'(~b);	// Pressed reads low
		repeat (HOLD) @(posedge clk);
		#10 btn = '1;
		repeat (HOLD) @(posedge clk);
	endtask

	task automatic press_and_model(input btn_t b);
		press_button(b);
		if (b.mode)
			exp_mode = (exp_mode == MODE_CLOCK) ? MODE_SETUP :
				(exp_mode == MODE_SETUP) ? MODE_ALARM : MODE_CLOCK;
		if (b.pos)
			exp_pos = (exp_pos == POS_SEC) ? POS_MIN : (exp_pos == POS_MIN) ? POS_HOU : POS_SEC;
		if (b.inc && exp_mode == MODE_SETUP)
			exp_time = bump(exp_time, exp_pos);
		if (b.inc && exp_mode == MODE_ALARM)
			exp_alarm = bump(exp_alarm, exp_pos);
	endtask

	// Steps to the field and then presses increment until it holds the target
	task automatic set_field(input pos_t p, input logic [5:0] target);
		for (int n = 0; n < 4 && exp_pos != p; n++)
			press_and_model(BTN_POS);
		for (int n = 0; n < 64 && field_of((exp_mode == MODE_ALARM) ? exp_alarm : exp_time, p)
				!= target; n++)
			press_and_model(BTN_INC);
	endtask

	task automatic read_display(output logic ok);
		int waited;
		ok = 1'b1;
		for (int d = 0; d < NUM_DIGITS; d++) begin
			waited = 0;
			@(negedge clk);
			while (seg_enb !== ~(6'b000001 << d) && waited < 4 * NUM_DIGITS) begin
				@(negedge clk);
				waited++;
			end
			if (seg_enb !== ~(6'b000001 << d)) begin
				timeout_errs++;
				$display("Display scan stalled at %0t, digit %0d never enabled", $time, d);
				ok = 1'b0;
				return;
			end
			rd_seg[d] = seg;
			rd_dp[d]  = seg_dp;
		end
	endtask

	task automatic check_shown(input hms_t t, input logic [5:0] dp);
		logic ok;
		read_display(ok);
		if (ok) begin
			for (int d = 0; d < NUM_DIGITS; d++)
				check_seg($sformatf("o_seg digit %0d", d), rd_seg[d], exp_seg(t, d));
			check_dp("o_seg_dp", rd_dp, dp);
		end
	endtask

	// --------------------
	// Tests
	// --------------------
	task automatic test_setup();
		press_and_model(BTN_MODE);
		set_field(POS_SEC, 6'd59);
		check_shown(exp_time, exp_points());
		press_and_model(BTN_INC);	// 59 wraps and minutes stay
		check_shown(exp_time, exp_points());
		set_field(POS_MIN, 6'd1);
		set_field(POS_HOU, 6'd23);
		check_shown(exp_time, exp_points());
		press_and_model(BTN_INC);
		check_shown(exp_time, exp_points());
		repeat (2 * SEC_DIV) @(posedge clk);	// Frozen in setup
		check_shown(exp_time, exp_points());
	endtask

	task automatic test_carry();
		int unsigned start;
		logic ok;
		logic found;
		set_field(POS_HOU, 6'd23);
		set_field(POS_MIN, 6'd59);
		set_field(POS_SEC, 6'd58);
		check_shown(exp_time, exp_points());
		press_and_model(BTN_MODE);
		press_and_model(BTN_MODE);
		start = cycle_cnt;
		found = 1'b0;
		while (!found && cycle_cnt - start < 5 * SEC_DIV) begin
			read_display(ok);
			found = ok && shows('0);
		end
		if (!found) begin
			timeout_errs++;
			$display("Running time did not roll over to 00:00:00 within %0d cycles", 5 * SEC_DIV);
		end
	endtask

	task automatic test_points();
		logic ok;
		for (int m = 0; m < 3; m++) begin
			for (int p = 0; p < 3; p++) begin
				read_display(ok);
				if (ok)
					check_dp($sformatf("o_seg_dp %s %s", exp_mode.name(), exp_pos.name()),
						rd_dp, exp_points());
				press_and_model(BTN_POS);
			end
			press_and_model(BTN_MODE);
		end
	endtask

	task automatic test_alarm();
		int unsigned start;
		press_and_model(BTN_MODE);
		press_and_model(BTN_MODE);
		set_field(POS_MIN, 6'd1);	// Alarm at 00:01:00
		check_shown(exp_alarm, exp_points());
		press_and_model(BTN_ALARM);
		press_and_model(BTN_MODE);
		start = cycle_cnt;
		while (alarm !== 1'b1 && cycle_cnt - start < 120 * SEC_DIV)
			@(negedge clk);
		if (alarm !== 1'b1) begin
			timeout_errs++;
			$display("o_alarm did not rise within %0d cycles", 120 * SEC_DIV);
		end else begin
			for (int n = 0; n < 3 * SEC_DIV && alarm === 1'b1; n++)
				@(negedge clk);
			check_bit("o_alarm", alarm, 1'b1);	// Latched past the match
		end
		press_and_model(BTN_ALARM);
		@(negedge clk);
		check_bit("o_alarm", alarm, 1'b0);
	endtask

	initial begin
		btn = '1;
		for (int n = 0; n < 20 && rst_n !== 1'b1; n++)
			@(posedge clk);
		if (rst_n !== 1'b1) begin
			timeout_errs++;
			$display("Reset never released");
		end else begin
			check_shown('0, 6'b000000);
			check_bit("o_alarm", alarm, 1'b0);
			test_setup();
			test_carry();
			test_points();
			test_alarm();
		end
		$display("Errors: %0d value mismatches, %0d timeouts", value_errs, timeout_errs);
		if (value_errs + timeout_errs == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule
